/* hw/cpu_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

// instruction fetch, data returns one cycle after read
interface cpu_ibus_if;
	logic                    read;
	logic [`CPU_IADDR_W-1:0] address;
	logic [31:0]             rddata;

	modport master (
		output read,
		output address,
		input  rddata
	);

	modport slave (
		input  read,
		input  address,
		output rddata
	);
endinterface

// data access, request held while stall is high
interface cpu_dbus_if;
	logic        read;
	logic        write;
	logic [31:0] address;
	logic [31:0] wrdata;
	logic [31:0] rddata;
	logic        stall;

	modport master (
		output read,
		output write,
		output address,
		output wrdata,
		input  rddata,
		input  stall
	);

	modport slave (
		input  read,
		input  write,
		input  address,
		input  wrdata,
		output rddata,
		output stall
	);
endinterface

`default_nettype wire

/* hw/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_core (
	input  logic               clk,
	input  logic               rst,
	cpu_ibus_if.master         ibus,
	cpu_dbus_if.master         dbus,
	output logic               wb_valid,
	output cpu_pkg::reg_addr_t wb_rd,
	output logic [31:0]        wb_data,
	output logic               hilo_valid,
	output logic [63:0]        hilo_value
);

logic stall_if;
logic stall_id;
logic stall_ex;
logic stall_wb;
logic flush_ex;

logic [`CPU_IADDR_W-1:0] pc;
logic                    fetch_valid;
logic [31:0]             instr;

cpu_pkg::reg_addr_t       dec_rs_addr;
cpu_pkg::reg_addr_t       dec_rt_addr;
logic                     dec_uses_rs;
logic                     dec_uses_rt;
cpu_pkg::reg_addr_t [1:0] reg_raddr;
logic [1:0][31:0]         reg_rdata;
logic                     rf_we;

cpu_pkg::pipeline_decode_t pipe_decode;
cpu_pkg::pipeline_decode_t pipe_decode_d;
cpu_pkg::pipeline_exec_t   pipe_exec;
cpu_pkg::pipeline_exec_t   pipe_exec_d;
cpu_pkg::hilo_req_t        hilo_req;
cpu_pkg::hilo_req_t        hilo_req_d;
logic [63:0]               hilo_q;
logic [63:0]               hilo_fwd;
logic [31:0]               wb_value;

// no read while stalled, so rddata holds the decoded word
assign ibus.read    = ~rst && ~stall_if;
assign ibus.address = pc;

always_ff @(posedge clk) begin
	if (rst) begin
		pc <= '0;
	end else if (~stall_if) begin
		pc <= pc + 1'b1;
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		fetch_valid <= 1'b0;
	end else if (~stall_id) begin
		fetch_valid <= ibus.read;
	end
end

assign instr        = fetch_valid ? ibus.rddata : '0;
assign reg_raddr[0] = dec_rs_addr;
assign reg_raddr[1] = dec_rt_addr;

ctrl i_ctrl (
	.clk,
	.rst,
	.decode_rs      ( dec_rs_addr        ),
	.decode_rt      ( dec_rt_addr        ),
	.decode_uses_rs ( dec_uses_rs        ),
	.decode_uses_rt ( dec_uses_rt        ),
	.ex_load        ( pipe_decode_d.load ),
	.ex_rd          ( pipe_decode_d.rd   ),
	.dbus_stall     ( dbus.stall         ),
	.stall_if,
	.stall_id,
	.stall_ex,
	.flush_ex,
	.stall_wb
);

decode i_decode (
	.instr,
	.rs_addr ( dec_rs_addr  ),
	.rt_addr ( dec_rt_addr  ),
	.uses_rs ( dec_uses_rs  ),
	.uses_rt ( dec_uses_rt  ),
	.rs_data ( reg_rdata[0] ),
	.rt_data ( reg_rdata[1] ),
	.result  ( pipe_decode  )
);

regfile i_regfile (
	.clk,
	.rst,
	.we    ( rf_we          ),
	.waddr ( pipe_exec_d.rd ),
	.wdata ( wb_value       ),
	.raddr ( reg_raddr      ),
	.rdata ( reg_rdata      )
);

always_ff @(posedge clk) begin
	if (rst || flush_ex) begin
		pipe_decode_d <= '0;
	end else if (~stall_ex) begin
		pipe_decode_d <= pipe_decode;
	end
end

// pending HILO write in write back goes straight to execute
assign hilo_fwd = hilo_req_d.we ? hilo_req_d.wdata : hilo_q;

exec i_exec (
	.data    ( pipe_decode_d ),
	.wb      ( pipe_exec_d   ),
	.wb_data ( wb_value      ),
	.hilo    ( hilo_fwd      ),
	.result  ( pipe_exec     ),
	.hilo_req,
	.dbus
);

always_ff @(posedge clk) begin
	if (rst) begin
		pipe_exec_d <= '0;
		hilo_req_d  <= '0;
	end else if (~stall_wb) begin
		pipe_exec_d <= pipe_exec;
		hilo_req_d  <= hilo_req;
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		hilo_q <= '0;
	end else if (hilo_valid) begin
		hilo_q <= hilo_req_d.wdata;
	end
end

// write back retires once, on the cycle it leaves the stage
assign wb_value   = pipe_exec_d.load ? dbus.rddata : pipe_exec_d.result;
assign rf_we      = pipe_exec_d.reg_write && (pipe_exec_d.rd != '0) && ~stall_wb;
assign wb_valid   = rf_we;
assign wb_rd      = pipe_exec_d.rd;
assign wb_data    = wb_value;
assign hilo_valid = hilo_req_d.we && ~stall_wb;
assign hilo_value = hilo_req_d.wdata;

endmodule

`default_nettype wire

/* hw/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// general purpose registers
`define CPU_REG_NUM 32

// memory depths in words
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 64

// word address widths
`define CPU_IADDR_W 8
`define CPU_DADDR_W 6

`endif

/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

typedef logic [4:0] reg_addr_t;

// unknown encodings decode to OP_NOP
typedef enum logic [3:0] {
	OP_NOP,
	OP_ADDU,
	OP_SUBU,
	OP_AND,
	OP_OR,
	OP_XOR,
	OP_SLT,
	OP_ADDIU,
	OP_ORI,
	OP_LUI,
	OP_LW,
	OP_SW,
	OP_MULTU,
	OP_MFHI,
	OP_MFLO
} op_t;

typedef struct packed {
	op_t         op;
	reg_addr_t   rs_addr;
	reg_addr_t   rt_addr;
	logic [31:0] rs_data;
	logic [31:0] rt_data;
	logic [31:0] imm;
	reg_addr_t   rd;
	logic        reg_write;
	logic        load;
	logic        store;
	logic        hilo_write;
} pipeline_decode_t;

typedef struct packed {
	op_t         op;
	reg_addr_t   rd;
	logic [31:0] result;
	logic        load;
	logic        reg_write;
} pipeline_exec_t;

typedef struct packed {
	logic        we;
	logic [63:0] wdata;
} hilo_req_t;

endpackage

`default_nettype wire

/* hw/cpu_system.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_system (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    prog_we,
	input  logic [`CPU_IADDR_W-1:0] prog_addr,
	input  logic [31:0]             prog_data,
	input  logic                    mem_wait,
	output logic                    wb_valid,
	output cpu_pkg::reg_addr_t      wb_rd,
	output logic [31:0]             wb_data,
	output logic                    hilo_valid,
	output logic [63:0]             hilo_value
);

cpu_ibus_if ibus ();
cpu_dbus_if dbus ();

cpu_core i_cpu_core (
	.clk,
	.rst,
	.ibus       ( ibus.master ),
	.dbus       ( dbus.master ),
	.wb_valid,
	.wb_rd,
	.wb_data,
	.hilo_valid,
	.hilo_value
);

soc_mem i_soc_mem (
	.clk,
	.rst,
	.prog_we,
	.prog_addr,
	.prog_data,
	.mem_wait,
	.ibus      ( ibus.slave ),
	.dbus      ( dbus.slave )
);

endmodule

`default_nettype wire

/* hw/ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl (
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::reg_addr_t decode_rs,
	input  cpu_pkg::reg_addr_t decode_rt,
	input  logic               decode_uses_rs,
	input  logic               decode_uses_rt,
	input  logic               ex_load,
	input  cpu_pkg::reg_addr_t ex_rd,
	input  logic               dbus_stall,
	output logic               stall_if,
	output logic               stall_id,
	output logic               stall_ex,
	output logic               flush_ex,
	output logic               stall_wb
);

logic rs_hit;
logic rt_hit;
logic load_use;

assign rs_hit = decode_uses_rs && (decode_rs == ex_rd);
assign rt_hit = decode_uses_rt && (decode_rt == ex_rd);

// the flushed bubble clears ex_load, so the hazard lasts one cycle
assign load_use = ex_load && (ex_rd != '0) && (rs_hit || rt_hit);

always_comb begin
	stall_if = 1'b0;
	stall_id = 1'b0;
	stall_ex = 1'b0;
	stall_wb = 1'b0;
	flush_ex = 1'b0;
	// bus stall wins over the hazard
	if (dbus_stall) begin
		stall_if = 1'b1;
		stall_id = 1'b1;
		stall_ex = 1'b1;
		stall_wb = 1'b1;
	end else if (load_use) begin
		stall_if = 1'b1;
		stall_id = 1'b1;
		flush_ex = 1'b1;
	end
end

endmodule

`default_nettype wire

/* hw/decode.sv */
`timescale 1ns/1ps
`default_nettype none

module decode (
	input  logic [31:0]               instr,
	output cpu_pkg::reg_addr_t        rs_addr,
	output cpu_pkg::reg_addr_t        rt_addr,
	output logic                      uses_rs,
	output logic                      uses_rt,
	input  logic [31:0]               rs_data,
	input  logic [31:0]               rt_data,
	output cpu_pkg::pipeline_decode_t result
);

logic [5:0]         opcode;
logic [5:0]         funct;
logic [15:0]        imm16;
cpu_pkg::reg_addr_t rd_field;
cpu_pkg::op_t       op;

assign opcode   = instr[31:26];
assign funct    = instr[5:0];
assign imm16    = instr[15:0];
assign rd_field = instr[15:11];
assign rs_addr  = instr[25:21];
assign rt_addr  = instr[20:16];

always_comb begin
	op = cpu_pkg::OP_NOP;
	case (opcode)
		6'h00: begin
			case (funct)
				6'h10: op = cpu_pkg::OP_MFHI;
				6'h12: op = cpu_pkg::OP_MFLO;
				6'h19: op = cpu_pkg::OP_MULTU;
				6'h21: op = cpu_pkg::OP_ADDU;
				6'h23: op = cpu_pkg::OP_SUBU;
				6'h24: op = cpu_pkg::OP_AND;
				6'h25: op = cpu_pkg::OP_OR;
				6'h26: op = cpu_pkg::OP_XOR;
				6'h2a: op = cpu_pkg::OP_SLT;
				default: op = cpu_pkg::OP_NOP;
			endcase
		end
		6'h09: op = cpu_pkg::OP_ADDIU;
		6'h0d: op = cpu_pkg::OP_ORI;
		6'h0f: op = cpu_pkg::OP_LUI;
		6'h23: op = cpu_pkg::OP_LW;
		6'h2b: op = cpu_pkg::OP_SW;
		default: op = cpu_pkg::OP_NOP;
	endcase
end

always_comb begin
	result         = '0;
	result.op      = op;
	result.rs_addr = rs_addr;
	result.rt_addr = rt_addr;
	result.rs_data = rs_data;
	result.rt_data = rt_data;
	uses_rs        = 1'b0;
	uses_rt        = 1'b0;
	case (op)
		cpu_pkg::OP_ADDU, cpu_pkg::OP_SUBU, cpu_pkg::OP_AND,
		cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_SLT: begin
			uses_rs          = 1'b1;
			uses_rt          = 1'b1;
			result.rd        = rd_field;
			result.reg_write = 1'b1;
		end
		cpu_pkg::OP_MULTU: begin
			uses_rs           = 1'b1;
			uses_rt           = 1'b1;
			result.hilo_write = 1'b1;
		end
		cpu_pkg::OP_MFHI, cpu_pkg::OP_MFLO: begin
			result.rd        = rd_field;
			result.reg_write = 1'b1;
		end
		cpu_pkg::OP_ADDIU, cpu_pkg::OP_LW: begin
			uses_rs          = 1'b1;
			result.rd        = rt_addr;
			result.reg_write = 1'b1;
			result.load      = (op == cpu_pkg::OP_LW);
			result.imm       = {{16{imm16[15]}}, imm16};
		end
		cpu_pkg::OP_SW: begin
			uses_rs      = 1'b1;
			uses_rt      = 1'b1;
			result.store = 1'b1;
			result.imm   = {{16{imm16[15]}}, imm16};
		end
		cpu_pkg::OP_ORI: begin
			uses_rs          = 1'b1;
			result.rd        = rt_addr;
			result.reg_write = 1'b1;
			result.imm       = {16'h0, imm16};
		end
		cpu_pkg::OP_LUI: begin
			result.rd        = rt_addr;
			result.reg_write = 1'b1;
			result.imm       = {imm16, 16'h0};
		end
		default: begin
			result.reg_write = 1'b0;
		end
	endcase
end

endmodule

`default_nettype wire

/* hw/exec.sv */
`timescale 1ns/1ps
`default_nettype none

module exec (
	input  cpu_pkg::pipeline_decode_t data,
	input  cpu_pkg::pipeline_exec_t   wb,
	input  logic [31:0]               wb_data,
	input  logic [63:0]               hilo,
	output cpu_pkg::pipeline_exec_t   result,
	output cpu_pkg::hilo_req_t        hilo_req,
	cpu_dbus_if.master                dbus
);

logic        fwd_rs;
logic        fwd_rt;
logic [31:0] rs_val;
logic [31:0] rt_val;
logic [31:0] sum;

// forward from write back
assign fwd_rs = wb.reg_write && (wb.rd != '0) && (wb.rd == data.rs_addr);
assign fwd_rt = wb.reg_write && (wb.rd != '0) && (wb.rd == data.rt_addr);
assign rs_val = fwd_rs ? wb_data : data.rs_data;
assign rt_val = fwd_rt ? wb_data : data.rt_data;

// also the effective address for loads and stores
assign sum = rs_val + data.imm;

always_comb begin
	result.op        = data.op;
	result.rd        = data.rd;
	result.load      = data.load;
	result.reg_write = data.reg_write;
	case (data.op)
		cpu_pkg::OP_ADDU:  result.result = rs_val + rt_val;
		cpu_pkg::OP_SUBU:  result.result = rs_val - rt_val;
		cpu_pkg::OP_AND:   result.result = rs_val & rt_val;
		cpu_pkg::OP_OR:    result.result = rs_val | rt_val;
		cpu_pkg::OP_XOR:   result.result = rs_val ^ rt_val;
		cpu_pkg::OP_SLT:   result.result = {31'h0, $signed(rs_val) < $signed(rt_val)};
		cpu_pkg::OP_ADDIU: result.result = sum;
		cpu_pkg::OP_ORI:   result.result = rs_val | data.imm;
		cpu_pkg::OP_LUI:   result.result = data.imm;
		cpu_pkg::OP_MFHI:  result.result = hilo[63:32];
		cpu_pkg::OP_MFLO:  result.result = hilo[31:0];
		default:           result.result = sum;
	endcase
end

// unsigned 32x32 product
assign hilo_req.we    = data.hilo_write;
assign hilo_req.wdata = {32'h0, rs_val} * {32'h0, rt_val};

assign dbus.read    = data.load;
assign dbus.write   = data.store;
assign dbus.address = sum;
assign dbus.wrdata  = rt_val;

endmodule

`default_nettype wire

/* hw/regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module regfile (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     we,
	input  cpu_pkg::reg_addr_t       waddr,
	input  logic [31:0]              wdata,
	input  cpu_pkg::reg_addr_t [1:0] raddr,
	output logic [1:0][31:0]         rdata
);

logic [31:0] regs [`CPU_REG_NUM];

always_ff @(posedge clk) begin
	if (rst) begin
		for (int i = 0; i < `CPU_REG_NUM; i++) begin
			regs[i] <= '0;
		end
	end else if (we && (waddr != '0)) begin
		regs[waddr] <= wdata;
	end
end

// same-cycle write shows through
always_comb begin
	for (int i = 0; i < 2; i++) begin
		if (raddr[i] == '0) begin
			rdata[i] = '0;
		end else if (we && (raddr[i] == waddr)) begin
			rdata[i] = wdata;
		end else begin
			rdata[i] = regs[raddr[i]];
		end
	end
end

endmodule

`default_nettype wire

/* hw/soc_mem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module soc_mem (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    prog_we,
	input  logic [`CPU_IADDR_W-1:0] prog_addr,
	input  logic [31:0]             prog_data,
	input  logic                    mem_wait,
	cpu_ibus_if.slave               ibus,
	cpu_dbus_if.slave               dbus
);

logic [31:0]             imem [`CPU_IMEM_DEPTH];
logic [31:0]             dmem [`CPU_DMEM_DEPTH];
logic [31:0]             irdata;
logic [31:0]             drdata;
logic [`CPU_DADDR_W-1:0] daddr;

// byte address in, word index out
assign daddr      = dbus.address[`CPU_DADDR_W+1:2];
assign dbus.stall = mem_wait && (dbus.read || dbus.write);

always_ff @(posedge clk) begin
	if (prog_we) begin
		imem[prog_addr] <= prog_data;
	end
	if (ibus.read) begin
		irdata <= imem[ibus.address];
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
			dmem[i] <= '0;
		end
	end else if (dbus.write && !dbus.stall) begin
		dmem[daddr] <= dbus.wrdata;
	end
end

// held until the next accepted read
always_ff @(posedge clk) begin
	if (dbus.read && !dbus.stall) begin
		drdata <= dmem[daddr];
	end
end

assign ibus.rddata = irdata;
assign dbus.rddata = drdata;

endmodule

`default_nettype wire

/* sim.f */
+incdir+hw
hw/cpu_pkg.sv
hw/cpu_bus_if.sv
hw/ctrl.sv
hw/decode.sv
hw/regfile.sv
hw/exec.sv
hw/cpu_core.sv
hw/soc_mem.sv
hw/cpu_system.sv
verification/tb_clock_gen.sv
verification/cpu_sva.sv
verification/tb_cpu_system.sv

/* verification/cpu_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_sva (
	input logic        clk,
	input logic        rst,
	input logic        wb_valid,
	input logic        dbus_read,
	input logic        dbus_write,
	input logic        dbus_stall,
	input logic [31:0] dbus_address,
	input logic [31:0] dbus_wrdata
);

no_read_and_write: assert property (@(posedge clk) disable iff (rst)
	!(dbus_read && dbus_write))
	else $error("dbus read and write strobes high together");

// a stalled request stays put until accepted
req_held_on_stall: assert property (@(posedge clk) disable iff (rst)
	(dbus_read || dbus_write) && dbus_stall |=>
	$stable(dbus_read) && $stable(dbus_write) &&
	$stable(dbus_address) && $stable(dbus_wrdata))
	else $error("dbus request changed while stalled");

wb_quiet_in_reset: assert property (@(posedge clk)
	rst |=> !wb_valid)
	else $error("wb_valid high during or right after reset");

endmodule

bind cpu_core cpu_sva i_cpu_sva (
	.clk,
	.rst,
	.wb_valid,
	.dbus_read    ( dbus.read    ),
	.dbus_write   ( dbus.write   ),
	.dbus_stall   ( dbus.stall   ),
	.dbus_address ( dbus.address ),
	.dbus_wrdata  ( dbus.wrdata  )
);

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	input  logic hold,
	output logic clk,
	output logic rst
);

int rst_cycles;

initial begin
	clk = 1'b0;
	rst = 1'b1;
	rst_cycles = 0;
end

// 10 ns period
always #5 clk = ~clk;

// 16 cycles of reset, held longer while the program loads
always @(posedge clk) begin
	if (rst_cycles < 16) begin
		rst_cycles <= rst_cycles + 1;
	end else if (!hold) begin
		rst <= 1'b0;
	end
end

endmodule

`default_nettype wire

/* verification/tb_cpu_system.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module tb_cpu_system;

localparam int PROG_LEN   = 120;
localparam int IMG_LEN    = 160;
localparam int PAD_CYCLES = 20;
localparam int WAIT_MAX   = 4;
localparam int TIMEOUT    = IMG_LEN + 16 + PROG_LEN * (3 + WAIT_MAX) + PAD_CYCLES;

logic                    clk;
logic                    rst;
logic                    hold;
logic                    prog_we;
logic [`CPU_IADDR_W-1:0] prog_addr;
logic [31:0]             prog_data;
logic                    mem_wait;
logic                    wb_valid;
cpu_pkg::reg_addr_t      wb_rd;
logic [31:0]             wb_data;
logic                    hilo_valid;
logic [63:0]             hilo_value;

logic [31:0]        rng_state = 32'hf7f;
int                 wait_run = 0;
int                 cycle_count = 0;
cpu_pkg::op_t       g_op [PROG_LEN];
cpu_pkg::reg_addr_t g_rs [PROG_LEN];
cpu_pkg::reg_addr_t g_rt [PROG_LEN];
cpu_pkg::reg_addr_t g_rd [PROG_LEN];
logic [15:0]        g_imm [PROG_LEN];
logic [31:0]        image [IMG_LEN];

cpu_pkg::reg_addr_t exp_rd [$];
logic [31:0]        exp_data [$];
int                 exp_cat [$];
logic [63:0]        exp_hilo [$];
int                 model_wb = 0;
int                 model_hilo = 0;
int                 seen_wb = 0;
int                 seen_hilo = 0;
int                 test_checks [6] = '{default: 0};
int                 test_errors [6] = '{default: 0};
string              test_names [6] = '{"alu_imm_forwarding", "load_use", "store_load",
	"multu_hilo", "retire_order_under_wait", "retire_count_and_padding"};

tb_clock_gen i_tb_clock_gen (
	.hold,
	.clk,
	.rst
);

cpu_system i_cpu_system (
	.clk,
	.rst,
	.prog_we,
	.prog_addr,
	.prog_data,
	.mem_wait,
	.wb_valid,
	.wb_rd,
	.wb_data,
	.hilo_valid,
	.hilo_value
);

function automatic logic [15:0] lcg();
	rng_state = rng_state * 32'd1103515245 + 32'd12345;
	return rng_state[31:16];
endfunction

function automatic cpu_pkg::reg_addr_t rand_reg();
	logic [15:0] r;
	r = lcg();
	return {2'b00, r[2:0]};
endfunction

// MIPS32 encodings
function automatic logic [31:0] encode(input cpu_pkg::op_t op, input cpu_pkg::reg_addr_t rs,
	input cpu_pkg::reg_addr_t rt, input cpu_pkg::reg_addr_t rd, input logic [15:0] imm);
	case (op)
		cpu_pkg::OP_ADDU:  return {6'h00, rs, rt, rd, 5'h00, 6'h21};
		cpu_pkg::OP_SUBU:  return {6'h00, rs, rt, rd, 5'h00, 6'h23};
		cpu_pkg::OP_AND:   return {6'h00, rs, rt, rd, 5'h00, 6'h24};
		cpu_pkg::OP_OR:    return {6'h00, rs, rt, rd, 5'h00, 6'h25};
		cpu_pkg::OP_XOR:   return {6'h00, rs, rt, rd, 5'h00, 6'h26};
		cpu_pkg::OP_SLT:   return {6'h00, rs, rt, rd, 5'h00, 6'h2a};
		cpu_pkg::OP_MULTU: return {6'h00, rs, rt, 10'h000, 6'h19};
		cpu_pkg::OP_MFHI:  return {16'h0000, rd, 5'h00, 6'h10};
		cpu_pkg::OP_MFLO:  return {16'h0000, rd, 5'h00, 6'h12};
		cpu_pkg::OP_ADDIU: return {6'h09, rs, rt, imm};
		cpu_pkg::OP_ORI:   return {6'h0d, rs, rt, imm};
		cpu_pkg::OP_LUI:   return {6'h0f, 5'h00, rt, imm};
		cpu_pkg::OP_LW:    return {6'h23, rs, rt, imm};
		cpu_pkg::OP_SW:    return {6'h2b, rs, rt, imm};
		default:           return 32'h0000_0000;
	endcase
endfunction

task automatic build_program();
	logic [15:0] pick;
	for (int i = 0; i < PROG_LEN; i++) begin
		pick = lcg() % 16'd14;
		g_op[i] = cpu_pkg::op_t'(pick[3:0] + 4'd1);
		g_rs[i] = rand_reg();
		g_rt[i] = rand_reg();
		g_rd[i] = rand_reg();
		g_imm[i] = lcg();
		// loads and stores use r0 as base, word aligned, first 16 words
		if (g_op[i] inside {cpu_pkg::OP_LW, cpu_pkg::OP_SW}) begin
			g_rs[i] = '0;
			g_imm[i] = {10'h000, g_imm[i][3:0], 2'b00};
		end
		if (g_op[i] inside {cpu_pkg::OP_LUI, cpu_pkg::OP_MFHI, cpu_pkg::OP_MFLO}) begin
			g_rs[i] = '0;
		end
		// a load result feeds the next instruction, so load-use stalls are common
		if ((i > 0) && (g_op[i-1] == cpu_pkg::OP_LW) &&
			!(g_op[i] inside {cpu_pkg::OP_LW, cpu_pkg::OP_SW, cpu_pkg::OP_LUI,
			cpu_pkg::OP_MFHI, cpu_pkg::OP_MFLO})) begin
			g_rs[i] = g_rt[i-1];
		end
		image[i] = encode(g_op[i], g_rs[i], g_rt[i], g_rd[i], g_imm[i]);
	end
	for (int i = PROG_LEN; i < IMG_LEN; i++) begin
		image[i] = 32'h0000_0000;
	end
endtask

task automatic run_model();
	logic [31:0]        regs [8];
	logic [31:0]        dmem [`CPU_DMEM_DEPTH];
	logic [63:0]        hilo;
	logic [31:0]        a;
	logic [31:0]        b;
	logic [31:0]        value;
	logic [31:0]        sext;
	cpu_pkg::op_t       op;
	cpu_pkg::reg_addr_t dest;
	cpu_pkg::reg_addr_t prev_rd;
	logic               prev_load;
	logic               uses_rt;
	logic               hazard;
	int                 cat;
	regs = '{default: '0};
	dmem = '{default: '0};
	hilo = '0;
	prev_load = 1'b0;
	prev_rd = '0;
	for (int i = 0; i < PROG_LEN; i++) begin
		op = g_op[i];
		a = regs[g_rs[i][2:0]];
		b = regs[g_rt[i][2:0]];
		sext = {{16{g_imm[i][15]}}, g_imm[i]};
		value = '0;
		uses_rt = op inside {cpu_pkg::OP_ADDU, cpu_pkg::OP_SUBU, cpu_pkg::OP_AND,
			cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_SLT, cpu_pkg::OP_MULTU, cpu_pkg::OP_SW};
		hazard = prev_load && (prev_rd != '0) &&
			((g_rs[i] == prev_rd) || (uses_rt && (g_rt[i] == prev_rd)));
		case (op)
			cpu_pkg::OP_ADDU:  value = a + b;
			cpu_pkg::OP_SUBU:  value = a - b;
			cpu_pkg::OP_AND:   value = a & b;
			cpu_pkg::OP_OR:    value = a | b;
			cpu_pkg::OP_XOR:   value = a ^ b;
			cpu_pkg::OP_SLT:   value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			cpu_pkg::OP_ADDIU: value = a + sext;
			cpu_pkg::OP_ORI:   value = a | {16'h0000, g_imm[i]};
			cpu_pkg::OP_LUI:   value = {g_imm[i], 16'h0000};
			cpu_pkg::OP_LW:    value = dmem[(a + sext) / 4];
			cpu_pkg::OP_SW:    dmem[(a + sext) / 4] = b;
			cpu_pkg::OP_MFHI:  value = hilo[63:32];
			cpu_pkg::OP_MFLO:  value = hilo[31:0];
			cpu_pkg::OP_MULTU: begin
				hilo = {32'h0, a} * {32'h0, b};
				exp_hilo.push_back(hilo);
				model_hilo++;
			end
			default: value = '0;
		endcase
		dest = (op inside {cpu_pkg::OP_ADDIU, cpu_pkg::OP_ORI, cpu_pkg::OP_LUI,
			cpu_pkg::OP_LW}) ? g_rt[i] : g_rd[i];
		if (!(op inside {cpu_pkg::OP_SW, cpu_pkg::OP_MULTU}) && (dest != '0)) begin
			regs[dest[2:0]] = value;
			if (hazard) begin
				cat = 1;
			end else if (op == cpu_pkg::OP_LW) begin
				cat = 2;
			end else if (op inside {cpu_pkg::OP_MFHI, cpu_pkg::OP_MFLO}) begin
				cat = 3;
			end else begin
				cat = 0;
			end
			exp_rd.push_back(dest);
			exp_data.push_back(value);
			exp_cat.push_back(cat);
			model_wb++;
		end
		prev_load = (op == cpu_pkg::OP_LW);
		prev_rd = g_rt[i];
	end
endtask

task automatic tally(input int test, input logic ok);
	test_checks[test]++;
	if (!ok) begin
		test_errors[test]++;
	end
endtask

task automatic check_wb(input cpu_pkg::reg_addr_t rd, input logic [31:0] data);
	cpu_pkg::reg_addr_t e_rd;
	logic [31:0]        e_data;
	int                 cat;
	seen_wb++;
	if (exp_rd.size() == 0) begin
		$display("unexpected register write r%0d = 0x%h after the program retired", rd, data);
		tally(5, 1'b0);
		return;
	end
	e_rd = exp_rd.pop_front();
	e_data = exp_data.pop_front();
	cat = exp_cat.pop_front();
	if (rd !== e_rd) begin
		$display("Mismatch wb_rd: expected 0x%h, got 0x%h", e_rd, rd);
	end
	if (data !== e_data) begin
		$display("Mismatch wb_data: expected 0x%h, got 0x%h (r%0d)", e_data, data, e_rd);
	end
	tally(cat, (rd === e_rd) && (data === e_data));
	tally(4, (rd === e_rd) && (data === e_data));
endtask

task automatic check_hilo(input logic [63:0] value);
	logic [63:0] e_value;
	seen_hilo++;
	if (exp_hilo.size() == 0) begin
		$display("unexpected HILO write 0x%h after the program retired", value);
		tally(5, 1'b0);
		return;
	end
	e_value = exp_hilo.pop_front();
	if (value !== e_value) begin
		$display("Mismatch hilo_value: expected 0x%h, got 0x%h", e_value, value);
	end
	tally(3, value === e_value);
	tally(4, value === e_value);
endtask

// outputs settle by the falling edge
always @(negedge clk) begin
	if (!rst) begin
		if (wb_valid) begin
			check_wb(wb_rd, wb_data);
		end
		if (hilo_valid) begin
			check_hilo(hilo_value);
		end
	end
end

// about one cycle in four, no run longer than WAIT_MAX
always @(posedge clk) begin
	if (rst || (wait_run >= WAIT_MAX) || (lcg() % 16'd4 != 16'd0)) begin
		mem_wait <= 1'b0;
		wait_run <= 0;
	end else begin
		mem_wait <= 1'b1;
		wait_run <= wait_run + 1;
	end
end

always @(posedge clk) begin
	cycle_count <= cycle_count + 1;
	if (cycle_count == TIMEOUT) begin
		$display("timeout after %0d cycles, the core stopped retiring with %0d writes pending",
			cycle_count, exp_rd.size() + exp_hilo.size());
		$display("ERRORS FOUND");
		$finish;
	end
end

initial begin
	int total_checks;
	int total_errors;
	hold = 1'b1;
	prog_we = 1'b0;
	prog_addr = '0;
	prog_data = '0;
	mem_wait = 1'b0;
	total_checks = 0;
	total_errors = 0;
	build_program();
	run_model();
	for (int i = 0; i < IMG_LEN; i++) begin
		@(posedge clk);
		prog_we <= 1'b1;
		prog_addr <= i[`CPU_IADDR_W-1:0];
		prog_data <= image[i];
	end
	@(posedge clk);
	prog_we <= 1'b0;
	hold <= 1'b0;
	while (rst) begin
		@(negedge clk);
	end
	while ((exp_rd.size() != 0) || (exp_hilo.size() != 0)) begin
		@(negedge clk);
	end
	// NOP padding must stay quiet
	repeat (PAD_CYCLES) @(negedge clk);
	if ((seen_wb != model_wb) || (seen_hilo != model_hilo)) begin
		$display("retired %0d register and %0d HILO writes, model has %0d and %0d",
			seen_wb, seen_hilo, model_wb, model_hilo);
	end
	tally(5, (seen_wb == model_wb) && (seen_hilo == model_hilo));
	for (int t = 0; t < 6; t++) begin
		$display("test %s: %0d checks, %0d errors", test_names[t], test_checks[t],
			test_errors[t]);
		total_checks += test_checks[t];
		total_errors += test_errors[t];
	end
	$display("%0d checks, %0d errors", total_checks, total_errors);
	if (total_errors == 0) begin
		$display("NO ERRORS");
	end else begin
		$display("ERRORS FOUND");
	end
	$finish;
end

endmodule

`default_nettype wire
